/* design/address_scheduler.sv */
// ########################################
// Runs the element accesses of a vector load
// or store as Wishbone classic cycles, one
// element after the other. Flags misaligned
// element addresses before any cycle starts.
// ########################################

`timescale 1ns/1ps

module address_scheduler import vmem_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  valid,
  input  logic  load_ena,
  input  logic  store_ena,
  input  logic  stall,
  input  eew_t  eew,
  input  addr_t addr0,
  input  addr_t addr1,
  input  word_t storedata0,
  input  word_t storedata1,
  input  vl_t   vl,
  input  vl_t   ls_idx,
  input  logic  wb_ack,
  output logic  wb_cyc,
  output logic  wb_stb,
  output logic  wb_we,
  output addr_t wb_adr,
  output word_t wb_dat_o,
  output sel_t  wb_sel,
  output logic  arrived0,
  output logic  arrived1,
  output logic  busy,
  output logic  exception
);

  sched_state_t state, next_state;
  vl_t   remaining;
  logic  two_elem;
  logic  start;
  logic  misaligned;
  logic  in_access;
  addr_t cur_addr;
  word_t cur_data;

  function automatic logic is_misaligned(input eew_t w, input logic [1:0] off);
    case (w)
      EEW_BYTE: return 1'b0;
      EEW_HALF: return off[0];
      default:  return off != 2'b00; // Word and reserved code
    endcase
  endfunction

  function automatic sel_t byte_sel(input eew_t w, input logic [1:0] off);
    case (w)
      EEW_BYTE: return sel_t'(4'b0001 << off);
      EEW_HALF: return sel_t'(4'b0011 << off);
      default:  return 4'b1111;
    endcase
  endfunction

  // Replicate so that whichever lane is selected carries the data
  function automatic word_t place_store(input eew_t w, input word_t d);
    case (w)
      EEW_BYTE: return {4{d[7:0]}};
      EEW_HALF: return {2{d[15:0]}};
      default:  return d;
    endcase
  endfunction

  assign remaining  = vl - ls_idx;
  assign two_elem   = (remaining != vl_t'(1)); // Last element alone
  assign start      = valid & (load_ena | store_ena);
  assign misaligned = is_misaligned(eew, addr0[1:0]) |
                      (two_elem & is_misaligned(eew, addr1[1:0]));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: if (start) next_state = misaligned ? DONE : ACC0;
      ACC0: if (wb_ack) next_state = two_elem ? ACC1 : DONE;
      ACC1: if (wb_ack) next_state = DONE;
      DONE: if (!stall) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  assign in_access = (state == ACC0) || (state == ACC1);
  assign busy      = in_access | ((state == IDLE) & start);
  assign exception = (state == IDLE) & start & misaligned; // No bus cycle follows

  // Current element
  assign cur_addr = (state == ACC1) ? addr1 : addr0;
  assign cur_data = (state == ACC1) ? storedata1 : storedata0;

  assign wb_cyc   = in_access;
  assign wb_stb   = in_access;
  assign wb_we    = in_access & store_ena;
  assign wb_adr   = {cur_addr[31:2], 2'b00};
  assign wb_sel   = byte_sel(eew, cur_addr[1:0]);
  assign wb_dat_o = place_store(eew, cur_data);

  assign arrived0 = (state == ACC0) & wb_ack;
  assign arrived1 = (state == ACC1) & wb_ack;

endmodule

/* design/load_aligner.sv */
// ########################################
// Captures the loaded words of both elements
// and shifts them down by their byte offset
// for segment accesses.
// ########################################

`timescale 1ns/1ps

module load_aligner import vmem_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       arrived0,
  input  logic       arrived1,
  input  logic       segment_type,
  input  logic [1:0] offset0,
  input  logic [1:0] offset1,
  input  word_t      wb_dat_i,
  output word_t      load0,
  output word_t      load1
);

  word_t data0;
  word_t data1;

  // Byte offset times eight as a right shift
  function automatic word_t shift_word(input word_t w, input logic [1:0] off);
    logic [4:0] amount;
    amount = {3'b000, off} << BYTE_SHIFT;
    return w >> amount;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      data0 <= '0;
      data1 <= '0;
    end else begin
      if (arrived0) begin
        data0 <= wb_dat_i; // Element 0 kept until writeback
      end
      if (arrived1) begin
        data1 <= wb_dat_i;
      end
    end
  end

  assign load0 = segment_type ? shift_word(data0, offset0) : data0;
  assign load1 = segment_type ? shift_word(data1, offset1) : data1;

endmodule

/* design/mem_wb_latch.sv */
// ########################################
// Pipeline register between memory stage and
// writeback. Picks load or ALU data per lane
// and honors stall and flush.
// ########################################

`timescale 1ns/1ps

module mem_wb_latch import vmem_pkg::*; (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             valid,
  input  logic             load_ena,
  input  logic             busy,
  input  logic             exception,
  input  logic             stall,
  input  logic             flush,
  input  word_t            alu0,
  input  word_t            alu1,
  input  word_t            load0,
  input  word_t            load1,
  input  logic [LANES-1:0] wen,
  input  vreg_t            vd,
  input  woffset_t         woffset,
  input  vl_t              vl,
  output word_t            wb_wdat0,
  output word_t            wb_wdat1,
  output logic [LANES-1:0] wb_wen,
  output vreg_t            wb_vd,
  output woffset_t         wb_woffset,
  output vl_t              wb_vl,
  output logic             wb_valid,
  output logic             wb_exception
);

  word_t sel0;
  word_t sel1;
  logic  load;
  logic  exc_seen;

  assign sel0    = load_ena ? load0 : alu0;
  assign sel1    = load_ena ? load1 : alu1;
  assign load    = valid & ~busy;  // Instruction finished in this stage

  // Exception pulse held until writeback takes it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exc_seen <= 1'b0;
    end else if (flush || (load && !stall)) begin
      exc_seen <= 1'b0;
    end else if (exception) begin
      exc_seen <= 1'b1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_wdat0     <= '0;
      wb_wdat1     <= '0;
      wb_wen       <= '0;
      wb_vd        <= '0;
      wb_woffset   <= '0;
      wb_vl        <= '0;
      wb_valid     <= 1'b0;
      wb_exception <= 1'b0;
    end else if (flush) begin
      wb_wdat0     <= '0;
      wb_wdat1     <= '0;
      wb_wen       <= '0;
      wb_vd        <= '0;
      wb_woffset   <= '0;
      wb_vl        <= '0;
      wb_valid     <= 1'b0;
      wb_exception <= 1'b0;
    end else if (!stall) begin
      if (load) begin
        wb_wdat0     <= sel0;
        wb_wdat1     <= sel1;
        wb_wen       <= exc_seen ? '0 : wen; // Faulting access writes nothing
        wb_vd        <= vd;
        wb_woffset   <= woffset;
        wb_vl        <= vl;
        wb_valid     <= 1'b1;
        wb_exception <= exc_seen;
      end else begin
        // Bubble
        wb_wen       <= '0;
        wb_valid     <= 1'b0;
        wb_exception <= 1'b0;
      end
    end
  end

endmodule

/* design/vmem_pkg.sv */
// ########################################
// Shared widths, types and constants of the
// vector memory stage. Imported by every RTL
// block and by the testbench.
// ########################################

package vmem_pkg;

  // Data and address
  typedef logic [31:0] word_t;   // One element result or bus word
  typedef logic [31:0] addr_t;   // Byte address

  // Instruction tags
  typedef logic [1:0] eew_t;     // Element width code
  typedef logic [4:0] vreg_t;    // Destination vector register
  typedef logic [4:0] woffset_t; // Element offset in register group
  typedef logic [5:0] vl_t;      // Vector length and element index

  // Wishbone byte select
  typedef logic [3:0] sel_t;

  // Element width encodings
  localparam eew_t EEW_BYTE = 2'd0;
  localparam eew_t EEW_HALF = 2'd1;
  localparam eew_t EEW_WORD = 2'd2;

  // Two element lanes per instruction
  localparam int LANES = 2;

  // Bits per byte as a shift amount
  localparam int BYTE_SHIFT = 3;

  // Address scheduler FSM
  typedef enum logic [1:0] {
    IDLE,  // Waiting for a load or store
    ACC0,  // Element 0 on the bus
    ACC1,  // Element 1 on the bus
    DONE   // Finished, held until stall drops
  } sched_state_t;

endpackage

/* design/vmem_stage.sv */
// ########################################
// Memory stage of the two-lane vector pipe.
// Connects scheduler, load aligner and the
// writeback latch to the pipeline and bus.
// ########################################

`timescale 1ns/1ps

module vmem_stage import vmem_pkg::*; (
  input  logic             CLK,
  input  logic             nRST,
  // Pipeline side
  input  logic             valid,
  input  logic             load_ena,
  input  logic             store_ena,
  input  logic             segment_type,
  input  eew_t             eew,
  input  addr_t            addr0,        // ALU result lane 0
  input  addr_t            addr1,        // ALU result lane 1
  input  word_t            storedata0,
  input  word_t            storedata1,
  input  vreg_t            vd,
  input  woffset_t         woffset,
  input  vl_t              vl,
  input  vl_t              ls_idx,
  input  logic [LANES-1:0] wen,
  input  logic             stall,
  input  logic             flush,
  // Wishbone master
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output addr_t            wb_adr,
  output word_t            wb_dat_o,
  output sel_t             wb_sel,
  input  word_t            wb_dat_i,
  input  logic             wb_ack,
  // Writeback
  output word_t            wb_wdat0,
  output word_t            wb_wdat1,
  output logic [LANES-1:0] wb_wen,
  output vreg_t            wb_vd,
  output woffset_t         wb_woffset,
  output vl_t              wb_vl,
  output logic             wb_valid,
  output logic             wb_exception,
  output logic             busy
);

  logic  arrived0;
  logic  arrived1;
  logic  exception;
  word_t load0;
  word_t load1;

  address_scheduler i_address_scheduler (
    .CLK        (CLK),
    .nRST       (nRST),
    .valid      (valid),
    .load_ena   (load_ena),
    .store_ena  (store_ena),
    .stall      (stall),
    .eew        (eew),
    .addr0      (addr0),
    .addr1      (addr1),
    .storedata0 (storedata0),
    .storedata1 (storedata1),
    .vl         (vl),
    .ls_idx     (ls_idx),
    .wb_ack     (wb_ack),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o),
    .wb_sel     (wb_sel),
    .arrived0   (arrived0),
    .arrived1   (arrived1),
    .busy       (busy),
    .exception  (exception)
  );

  load_aligner i_load_aligner (
    .CLK          (CLK),
    .nRST         (nRST),
    .arrived0     (arrived0),
    .arrived1     (arrived1),
    .segment_type (segment_type),
    .offset0      (addr0[1:0]),
    .offset1      (addr1[1:0]),
    .wb_dat_i     (wb_dat_i),
    .load0        (load0),
    .load1        (load1)
  );

  // ALU results double as addresses for memory ops
  mem_wb_latch i_mem_wb_latch (
    .CLK          (CLK),
    .nRST         (nRST),
    .valid        (valid),
    .load_ena     (load_ena),
    .busy         (busy),
    .exception    (exception),
    .stall        (stall),
    .flush        (flush),
    .alu0         (addr0),
    .alu1         (addr1),
    .load0        (load0),
    .load1        (load1),
    .wen          (wen),
    .vd           (vd),
    .woffset      (woffset),
    .vl           (vl),
    .wb_wdat0     (wb_wdat0),
    .wb_wdat1     (wb_wdat1),
    .wb_wen       (wb_wen),
    .wb_vd        (wb_vd),
    .wb_woffset   (wb_woffset),
    .wb_vl        (wb_vl),
    .wb_valid     (wb_valid),
    .wb_exception (wb_exception)
  );

endmodule

/* list.f */
design/vmem_pkg.sv
design/address_scheduler.sv
design/load_aligner.sv
design/mem_wb_latch.sv
design/vmem_stage.sv
tests/vmem_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the vector memory stage testbench with Verilator and runs it.
# Exits with a non-zero status unless the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module vmem_stage_tb -o vmem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/vmem_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1

/* tests/vmem_stage_tb.sv */
// ########################################
// Testbench of the vector memory stage. Replays
// tests/vmem_trace.txt against the DUT, which talks
// to a Wishbone slave memory model of 64 words.
// ########################################

`timescale 1ns/1ps

module vmem_stage_tb import vmem_pkg::*; ();

  logic             CLK = 1'b0;
  logic             nRST;
  logic             valid;
  logic             load_ena;
  logic             store_ena;
  logic             segment_type;
  logic             stall;
  logic             flush;
  eew_t             eew;
  addr_t            addr0;
  addr_t            addr1;
  word_t            storedata0;
  word_t            storedata1;
  vreg_t            vd;
  woffset_t         woffset;
  vl_t              vl;
  vl_t              ls_idx;
  logic [LANES-1:0] wen;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  addr_t            wb_adr;
  word_t            wb_dat_o;
  sel_t             wb_sel;
  word_t            wb_dat_i = '0;
  logic             wb_ack = 1'b0;
  word_t            wb_wdat0;
  word_t            wb_wdat1;
  logic [LANES-1:0] wb_wen;
  vreg_t            wb_vd;
  woffset_t         wb_woffset;
  vl_t              wb_vl;
  logic             wb_valid;
  logic             wb_exception;
  logic             busy;

  word_t        mem [0:63];
  string        lines[$];
  int           accesses = 0;
  int           cycles = 0;
  int           limit = 0;
  int           errors = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  sched_state_t sched_state;

  vmem_stage i_vmem_stage (.*);

  assign sched_state = i_vmem_stage.i_address_scheduler.state;

  always #2 CLK = ~CLK; // 4 ns period

  // Slave memory model that acks one cycle after stb
  always @(posedge CLK) begin
    if (!nRST) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= word_t'(i) * 32'h01010101;
      end
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb && !wb_ack) begin
      wb_ack   <= 1'b1;
      wb_dat_i <= mem[wb_adr[7:2]];
      if (wb_we) begin
        for (int b = 0; b < 4; b++) begin
          if (wb_sel[b]) mem[wb_adr[7:2]][8*b +: 8] <= wb_dat_o[8*b +: 8]; // Byte lanes
        end
      end
    end else begin
      wb_ack <= 1'b0;
    end
  end

  // Completed bus cycles and run length
  always @(posedge CLK) begin
    if (wb_cyc && wb_stb && wb_ack) accesses <= accesses + 1;
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, scheduler in state %s", cycles, sched_state.name());
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string what, input int errs_before);
    string verdict;
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
      verdict = "failed";
    end else begin
      verdict = "ok";
    end
    $display("Test %0d (%s) %s", num, what, verdict);
  endtask

  function automatic string op_name(input int kind);
    case (kind)
      0:       return "alu";
      1:       return "load";
      default: return "store";
    endcase
  endfunction

  task automatic check_reset();
    int errs_before;
    errs_before = errors;
    check_value("wb_cyc", 32'd0, 32'(wb_cyc));
    check_value("wb_stb", 32'd0, 32'(wb_stb));
    check_value("wb_we", 32'd0, 32'(wb_we));
    check_value("busy", 32'd0, 32'(busy));
    check_value("wb_valid", 32'd0, 32'(wb_valid));
    check_value("wb_wen", 32'd0, 32'(wb_wen));
    check_value("wb_exception", 32'd0, 32'(wb_exception));
    report_test(0, "reset", errs_before);
  endtask

  task automatic run_line(input string line);
    int          num, kind, ew, seg, n_vl, n_idx, fl, exp_exc, exp_cnt;
    int          fields, start_cnt, waited, errs_before;
    logic [31:0] a0, a1, d0, d1, exp0, exp1;
    logic [1:0]  w, exp_wen;
    errs_before = errors;
    fields = $sscanf(line, "%d %d %d %d %h %h %h %h %d %d %b %d %h %h %d %d",
                     num, kind, ew, seg, a0, a1, d0, d1, n_vl, n_idx, w, fl,
                     exp0, exp1, exp_exc, exp_cnt);
    if (fields != 16) begin
      $display("Trace line could not be read: %s", line);
      errors++;
    end else begin
      @(posedge CLK);
      valid        <= 1'b1;
      load_ena     <= (kind == 1);
      store_ena    <= (kind == 2);
      segment_type <= seg[0];
      eew          <= eew_t'(ew);
      addr0        <= a0;
      addr1        <= a1;
      storedata0   <= d0;
      storedata1   <= d1;
      vl           <= vl_t'(n_vl);
      ls_idx       <= vl_t'(n_idx);
      wen          <= w;
      flush        <= (fl != 0);
      vd           <= vreg_t'(num);
      woffset      <= woffset_t'(num * 3);
      start_cnt = accesses;
      waited = 0;
      do begin
        @(negedge CLK);
        waited++;
      end while (busy);
      // Latch takes the instruction on this edge
      @(posedge CLK);
      valid     <= 1'b0;
      load_ena  <= 1'b0;
      store_ena <= 1'b0;
      flush     <= 1'b0;
      @(negedge CLK);
      assert (kind != 0 || waited == 1) else begin
        $display("Test %0d: ALU instruction did not pass straight through", num);
        errors++;
      end
      exp_wen = (fl != 0 || exp_exc != 0) ? 2'b00 : w;
      check_value("wb_valid", 32'(fl == 0), 32'(wb_valid));
      check_value("wb_wen", 32'(exp_wen), 32'(wb_wen));
      check_value("wb_wdat0", exp0, wb_wdat0);
      check_value("wb_wdat1", exp1, wb_wdat1);
      check_value("wb_exception", 32'(exp_exc), 32'(wb_exception));
      check_value("wb_vd", (fl != 0) ? 32'd0 : 32'(vreg_t'(num)), 32'(wb_vd));
      check_value("wb_woffset", (fl != 0) ? 32'd0 : 32'(woffset_t'(num * 3)),
                  32'(wb_woffset));
      check_value("wb_vl", (fl != 0) ? 32'd0 : 32'(vl_t'(n_vl)), 32'(wb_vl));
      check_value("bus accesses", 32'(exp_cnt), 32'(accesses - start_cnt));
      report_test(num, op_name(kind), errs_before);
    end
  endtask

  initial begin
    string line;
    int    fd;
    nRST         = 1'b0;
    valid        = 1'b0;
    load_ena     = 1'b0;
    store_ena    = 1'b0;
    segment_type = 1'b0;
    stall        = 1'b0;
    flush        = 1'b0;
    eew          = EEW_WORD;
    addr0        = '0;
    addr1        = '0;
    storedata0   = '0;
    storedata1   = '0;
    vd           = '0;
    woffset      = '0;
    vl           = '0;
    ls_idx       = '0;
    wen          = '0;
    fd = $fopen("tests/vmem_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file tests/vmem_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    limit = 20 * lines.size() + 50;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_reset();
    foreach (lines[i]) run_line(lines[i]);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && lines.size() > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tests/vmem_trace.txt */
# num op(0 alu, 1 load, 2 store) eew seg addr0 addr1 sdata0 sdata1 vl ls_idx wen flush
#   exp_wdat0 exp_wdat1 exp_exception exp_bus_accesses
1 0 2 0 12345678 9abcdef0 00000000 00000000 2 0 11 0 12345678 9abcdef0 0 0
2 1 2 0 00000010 00000014 00000000 00000000 2 0 11 0 04040404 05050505 0 2
3 2 2 0 00000020 00000024 cafef00d 11223344 2 0 00 0 00000020 00000024 0 2
4 1 2 0 00000020 00000024 00000000 00000000 2 0 11 0 cafef00d 11223344 0 2
5 2 1 0 0000002a 0000002c 0000beef 0000f00d 2 0 00 0 0000002a 0000002c 0 2
6 1 2 0 00000028 0000002c 00000000 00000000 2 0 11 0 beef0a0a 0b0bf00d 0 2
7 2 0 0 00000031 00000037 000000a5 0000005a 2 0 00 0 00000031 00000037 0 2
8 1 2 0 00000030 00000034 00000000 00000000 2 0 11 0 0c0ca50c 5a0d0d0d 0 2
9 1 0 1 0000002b 0000002e 00000000 00000000 2 0 11 0 000000be 00000b0b 0 2
10 1 1 1 00000032 00000040 00000000 00000000 5 4 01 0 00000c0c 0b0bf00d 0 1
11 2 2 0 00000041 00000044 deadbeef 12345678 2 0 11 0 00000041 00000044 1 0
12 2 1 0 00000050 00000053 0000aaaa 0000bbbb 2 0 11 0 00000050 00000053 1 0
13 1 2 0 00000040 00000050 00000000 00000000 2 0 11 0 10101010 14141414 0 2
14 1 2 0 00000008 0000000c 00000000 00000000 2 0 11 1 00000000 00000000 0 2
15 0 2 0 0badf00d 00c0ffee 00000000 00000000 2 0 10 0 0badf00d 00c0ffee 0 0
16 1 0 1 00000031 00000035 00000000 00000000 2 0 11 0 000c0ca5 005a0d0d 0 2
